/* rtl/conv_pkg.sv */
// Shared widths, beat flags and FSM states for the row convolution engine
// Modules take what they need by a wildcard import in the body
package conv_pkg;

    parameter int KW_MAX_DEF  = 7;                     // widest odd kernel the filter supports
    parameter int MEMBERS_DEF = 8;                     // number of parallel multiply-accumulators

    parameter int PIXEL_W  = 8;
    parameter int WEIGHT_W = 8;
    parameter int PSUM_W   = 24;                       // headroom for 255 channels of 8x8 products
    parameter int KW2_W    = 2;                        // half kernel width, kw/2
    parameter int COL_W    = 8;
    parameter int CIN_W    = 8;

    typedef logic signed [PIXEL_W-1:0]  pixel_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [PSUM_W-1:0]   psum_t;
    typedef logic        [KW2_W-1:0]    kw2_t;         // 0 means kw = 1, 3 means kw = 7
    typedef logic        [COL_W-1:0]    col_t;
    typedef logic        [CIN_W-1:0]    cin_t;

    // user flags that travel with every tagged beat
    typedef struct packed {
        kw2_t kw2;                                     // kernel of the row this beat belongs to
        logic is_config;                               // beat carries configuration, no pixel
        logic is_cin_last;                             // last channel of a column
        logic is_col_last;                             // beat belongs to the last column
        logic is_cols_1_k2;                            // column kw2 before the last one
    } beat_user_t;

    typedef enum logic {
        TAG_IDLE,                                      // waiting for a configuration beat
        TAG_STREAM                                     // counting channels and columns of a row
    } tagger_state_t;

endpackage

/* rtl/conv_beat_if.sv */
// One tagged beat going from the input side to the datapaths and the filter
// The tagger drives the source side, every other block only reads the sink side
`timescale 1ns/100ps

interface conv_beat_if #(
    parameter int MEMBERS = conv_pkg::MEMBERS_DEF
);
    import conv_pkg::*;

    logic       valid;                                 // taken when valid and aclken are both high
    pixel_t     pixel;
    beat_user_t user;
    weight_t    weights [MEMBERS];                     // one weight per member, set by the last config

    modport source (
        output valid, pixel, user, weights
    );

    modport sink (
        input valid, pixel, user, weights
    );

endinterface

/* rtl/beat_tagger.sv */
// Input side of the engine; registers each beat and tags it with its user flags
// A config beat sets the row shape and weights, then pixel beats stream column by column
`timescale 1ns/100ps

module beat_tagger #(
    parameter int MEMBERS = conv_pkg::MEMBERS_DEF
) (
    input  logic              aclk,
    input  logic              aclken,
    input  logic              rst_n,
    input  logic              in_valid,
    input  conv_pkg::pixel_t  in_pixel,
    input  logic              in_config,
    input  conv_pkg::kw2_t    in_kw2,
    input  conv_pkg::col_t    in_cols,
    input  conv_pkg::cin_t    in_cins,
    input  conv_pkg::weight_t in_weights [MEMBERS],
    conv_beat_if.source       beat
);
    import conv_pkg::*;

    tagger_state_t state;
    kw2_t          kw2_q;                              // kernel of the current row
    col_t          cols_q;                             // columns in the current row
    cin_t          cins_q;                             // channels per column
    col_t          col_cnt;
    cin_t          ch_cnt;
    logic          cin_last;
    logic          col_last;
    logic          cols_1_k2;

    assign cin_last  = (ch_cnt == cin_t'(cins_q - cin_t'(1)));
    assign col_last  = (col_cnt == col_t'(cols_q - col_t'(1)));
    assign cols_1_k2 = (col_cnt == col_t'(cols_q - col_t'(1) - col_t'(kw2_q))); // start of the right edge

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state      <= TAG_IDLE;
            beat.valid <= 1'b0;
            beat.user  <= '0;
            kw2_q      <= '0;
            cols_q     <= '0;
            cins_q     <= '0;
            col_cnt    <= '0;
            ch_cnt     <= '0;
        end else if (aclken) begin
            beat.valid <= 1'b0;                        // one tagged beat per taken input beat
            if (in_valid && in_config) begin
                kw2_q      <= in_kw2;
                cols_q     <= in_cols;
                cins_q     <= in_cins;
                col_cnt    <= '0;
                ch_cnt     <= '0;
                state      <= TAG_STREAM;
                beat.valid <= 1'b1;                    // the config itself goes on, it clears the chain
                beat.user  <= '{kw2: in_kw2, is_config: 1'b1, default: 1'b0};
            end else if (in_valid && state == TAG_STREAM) begin
                beat.valid <= 1'b1;
                beat.user  <= '{kw2: kw2_q, is_config: 1'b0, is_cin_last: cin_last,
                               is_col_last: col_last, is_cols_1_k2: cols_1_k2};
                if (cin_last) begin
                    ch_cnt  <= '0;
                    col_cnt <= col_t'(col_cnt + col_t'(1));
                    if (col_last) begin
                        state <= TAG_IDLE;             // row is complete, wait for the next config
                    end
                end else begin
                    ch_cnt <= cin_t'(ch_cnt + cin_t'(1));
                end
            end
        end
    end

    // pixel and weights are payload only
    always_ff @(posedge aclk) begin
        if (aclken && in_valid) begin
            beat.pixel <= in_pixel;
            if (in_config) begin
                beat.weights <= in_weights;            // held for the whole row
            end
        end
    end

endmodule

/* rtl/pad_filter.sv */
// Works out per member which partial sums may be handed on and which sums are finished
// Column edge registers plus lookup logic for every odd kernel up to KW_MAX give same padding
`timescale 1ns/100ps

module pad_filter #(
    parameter int KW_MAX  = conv_pkg::KW_MAX_DEF,
    parameter int MEMBERS = conv_pkg::MEMBERS_DEF
) (
    input  logic               aclk,
    input  logic               aclken,
    input  logic               rst_n,
    conv_beat_if.sink          beat,
    output logic [MEMBERS-1:1] mask_partial,
    output logic [MEMBERS-1:0] mask_full
);
    import conv_pkg::*;

    localparam int KW2_MAX = KW_MAX / 2;               // 7 gives 3, 5 gives 2, 3 gives 1

    kw2_t kw2;
    logic reg_clken;

    // the shift registers are indexed from 1 so kw2 selects them without an adder
    logic [KW2_MAX:0] col_end      [MEMBERS];          // bit 0 stays low for kw = 1
    logic [KW2_MAX:1] col_end_in   [MEMBERS];
    logic [KW2_MAX:1] col_start    [MEMBERS];
    logic [KW2_MAX:1] col_start_in [MEMBERS];

    logic [KW2_MAX:0] lut_allow_full [MEMBERS];        // one entry per kernel, picked by kw2
    logic [KW2_MAX:0] lut_stop_partial [MEMBERS-1:1];

    assign kw2       = beat.user.kw2;
    assign reg_clken = aclken && beat.valid && (beat.user.is_cin_last || beat.user.is_config);

    for (genvar m = 0; m < MEMBERS; m++) begin : g_edge
        // col_end walks from the column kw2 before the last to the last column
        assign col_end_in[m][1] = !beat.user.is_config && beat.user.is_cols_1_k2 && (kw2 != 0);
        // a config starts the left edge, otherwise the end of the last row wraps into it
        assign col_start_in[m][1] = beat.user.is_config ? (kw2 != 0) : col_end[m][kw2];

        for (genvar k = 2; k <= KW2_MAX; k++) begin : g_shift
            assign col_end_in[m][k]   = beat.user.is_config ? 1'b0 : col_end[m][k-1];
            assign col_start_in[m][k] = beat.user.is_config ? 1'b0 : col_start[m][k-1];
        end

        always_ff @(posedge aclk) begin
            if (!rst_n) begin
                col_end[m][KW2_MAX:1] <= '0;
                col_start[m]          <= '0;
            end else if (reg_clken) begin
                col_end[m][KW2_MAX:1] <= col_end_in[m];  // moves once per finished column
                col_start[m]          <= col_start_in[m];
            end
        end

        assign col_end[m][0] = 1'b0;
    end

    for (genvar m = 0; m < MEMBERS; m++) begin : g_full
        for (genvar k = 1; k <= KW2_MAX; k++) begin : g_kw
            localparam int KW = 2 * k + 1;
            localparam bit FULL_WINDOW = (m == KW - 1); // holds all kw taps of one window
            localparam bit EDGE_TAIL   = (m >= k) && (m < KW); // right edge windows, zero padded

            logic start_cols;                          // first kw2 columns, window not yet complete
            logic last_col;

            assign start_cols = |col_start[m][k:1];
            assign last_col   = col_end[m][k];

            assign lut_allow_full[m][k] = (FULL_WINDOW && !start_cols) || (EDGE_TAIL && last_col);
        end

        assign lut_allow_full[m][0] = (m == 0);       // kw = 1 has no neighbours, member 0 finishes
        assign mask_full[m]         = lut_allow_full[m][kw2];
    end

    for (genvar m = 1; m < MEMBERS; m++) begin : g_partial
        for (genvar k = 1; k <= KW2_MAX; k++) begin : g_kw
            localparam int KW = 2 * k + 1;
            localparam bit UNUSED = (m >= KW);        // members past the kernel take nothing

            // at the last column a hand-over would carry columns past the row into the next one
            assign lut_stop_partial[m][k] = UNUSED || col_end[m][k];
        end

        assign lut_stop_partial[m][0] = 1'b1;         // kw = 1 never hands over
        assign mask_partial[m]        = !lut_stop_partial[m][kw2];
    end

endmodule

/* rtl/psum_chain.sv */
// Member multiply-accumulators; each column's sums move one member up at channel end
// done marks the members whose sum is a finished output, as chosen by the pad filter
`timescale 1ns/100ps

module psum_chain #(
    parameter int KW_MAX  = conv_pkg::KW_MAX_DEF,
    parameter int MEMBERS = conv_pkg::MEMBERS_DEF
) (
    input  logic               aclk,
    input  logic               aclken,
    input  logic               rst_n,
    conv_beat_if.sink          beat,
    input  logic [MEMBERS-1:1] mask_partial,
    input  logic [MEMBERS-1:0] mask_full,
    output conv_pkg::psum_t    psum [MEMBERS],
    output logic [MEMBERS-1:0] done
);
    import conv_pkg::*;

    psum_t acc     [MEMBERS];                          // running sum of the current column
    psum_t prod    [MEMBERS];
    psum_t sum_now [MEMBERS];                          // acc with this beat's product included
    logic  take;
    logic  take_last;

    assign take      = aclken && beat.valid && !beat.user.is_config;
    assign take_last = take && beat.user.is_cin_last;

    for (genvar m = 0; m < MEMBERS; m++) begin : g_mac
        assign prod[m]    = beat.pixel * beat.weights[m]; // signed, extended to the sum width
        assign sum_now[m] = acc[m] + prod[m];

        always_ff @(posedge aclk) begin
            if (!rst_n) begin
                acc[m]  <= '0;
                done[m] <= 1'b0;
            end else begin
                done[m] <= take_last && mask_full[m];  // single cycle pulse, even if aclken drops
                if (aclken && beat.valid && beat.user.is_config) begin
                    acc[m] <= '0;                      // a new row starts with an empty chain
                end else if (take_last) begin
                    if (m == 0) begin
                        acc[m] <= '0;                  // member 0 always opens a new window
                    end else if (mask_partial[m]) begin
                        acc[m] <= sum_now[m-1];        // neighbour's window moves one column on
                    end else begin
                        acc[m] <= '0;
                    end
                end else if (take) begin
                    acc[m] <= sum_now[m];              // more channels of the same column
                end
            end
        end

        // finished value is held until the next channel end
        always_ff @(posedge aclk) begin
            if (take_last) begin
                psum[m] <= sum_now[m];
            end
        end
    end

endmodule

/* rtl/output_collector.sv */
// Output side; queues finished sums and emits one per cycle in column order
// row_done goes with the sum of the last column of a row
`timescale 1ns/100ps

module output_collector #(
    parameter int KW_MAX  = conv_pkg::KW_MAX_DEF,
    parameter int MEMBERS = conv_pkg::MEMBERS_DEF
) (
    input  logic               aclk,
    input  logic               aclken,
    input  logic               rst_n,
    conv_beat_if.sink          beat,
    input  conv_pkg::psum_t    psum [MEMBERS],
    input  logic [MEMBERS-1:0] done,
    output logic               out_valid,
    output conv_pkg::psum_t    out_sum,
    output conv_pkg::col_t     out_col,
    output logic               row_done
);
    import conv_pkg::*;

    localparam int PTR_W  = (MEMBERS > 1) ? $clog2(MEMBERS) : 1;
    localparam int CNT_W  = $clog2(MEMBERS + 1);
    localparam int PUSH_W = $clog2(KW_MAX / 2 + 2); // at most kw2+1 sums finish together

    psum_t             q_sum  [MEMBERS];
    logic              q_last [MEMBERS];               // marks the last column of a row
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [PTR_W-1:0]  push_slot [MEMBERS];
    logic [PTR_W-1:0]  last_slot;
    logic [PUSH_W-1:0] push_n;
    logic              col_last_q;                     // done of this cycle comes from the last column
    logic              pop;
    col_t              col_cnt;

    // higher members hold older columns, so they go into the queue first
    always_comb begin
        int n;
        n = 0;
        for (int m = MEMBERS - 1; m >= 0; m--) begin
            push_slot[m] = PTR_W'((int'(wr_ptr) + n) % MEMBERS);
            if (done[m]) begin
                n++;
            end
        end
        push_n    = PUSH_W'(n);
        last_slot = PTR_W'((int'(wr_ptr) + n + MEMBERS - 1) % MEMBERS);
    end

    assign pop = aclken && (count != 0);

    always_ff @(posedge aclk) begin
        for (int m = 0; m < MEMBERS; m++) begin
            if (done[m]) begin
                q_sum[push_slot[m]]  <= psum[m];
                q_last[push_slot[m]] <= 1'b0;
            end
        end
        if (col_last_q && push_n != 0) begin
            q_last[last_slot] <= 1'b1;                 // lowest finishing member is column cols-1
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            col_last_q <= 1'b0;
            col_cnt    <= '0;
            out_valid  <= 1'b0;
            row_done   <= 1'b0;
            out_col    <= '0;
        end else begin
            if (aclken && beat.valid && beat.user.is_cin_last) begin
                col_last_q <= beat.user.is_col_last; // lines up with done from the chain
            end
            wr_ptr    <= PTR_W'((int'(wr_ptr) + int'(push_n)) % MEMBERS);
            count     <= CNT_W'(count + push_n - CNT_W'(pop));
            out_valid <= pop;
            row_done  <= pop && q_last[rd_ptr];
            if (pop) begin
                rd_ptr  <= PTR_W'((int'(rd_ptr) + 1) % MEMBERS);
                out_col <= col_cnt;
                col_cnt <= q_last[rd_ptr] ? col_t'(0) : col_t'(col_cnt + col_t'(1));
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            out_sum <= q_sum[rd_ptr];
        end
    end

endmodule

/* rtl/conv_row_engine.sv */
// Top level of the same-padded row convolution engine
// Input side tags beats, the filter and chain compute sums, the collector emits them
`timescale 1ns/100ps

module conv_row_engine #(
    parameter int KW_MAX  = conv_pkg::KW_MAX_DEF,
    parameter int MEMBERS = conv_pkg::MEMBERS_DEF
) (
    input  logic              aclk,
    input  logic              aclken,
    input  logic              rst_n,
    input  logic              in_valid,
    input  conv_pkg::pixel_t  in_pixel,
    input  logic              in_config,
    input  conv_pkg::kw2_t    in_kw2,
    input  conv_pkg::col_t    in_cols,
    input  conv_pkg::cin_t    in_cins,
    input  conv_pkg::weight_t in_weights [MEMBERS],
    output logic              out_valid,
    output conv_pkg::psum_t   out_sum,
    output conv_pkg::col_t    out_col,
    output logic              row_done
);
    import conv_pkg::*;

    logic [MEMBERS-1:1] mask_partial;
    logic [MEMBERS-1:0] mask_full;
    psum_t              psum [MEMBERS];
    logic [MEMBERS-1:0] done;

    conv_beat_if #(.MEMBERS(MEMBERS)) beat_if ();

    beat_tagger #(.MEMBERS(MEMBERS)) u_beat_tagger (
        .aclk, .aclken, .rst_n, .in_valid, .in_pixel, .in_config,
        .in_kw2, .in_cols, .in_cins, .in_weights,
        .beat (beat_if.source)
    );

    pad_filter #(.KW_MAX(KW_MAX), .MEMBERS(MEMBERS)) u_pad_filter (
        .aclk, .aclken, .rst_n,
        .beat (beat_if.sink),
        .mask_partial, .mask_full
    );

    psum_chain #(.KW_MAX(KW_MAX), .MEMBERS(MEMBERS)) u_psum_chain (
        .aclk, .aclken, .rst_n,
        .beat (beat_if.sink),
        .mask_partial, .mask_full, .psum, .done
    );

    output_collector #(.KW_MAX(KW_MAX), .MEMBERS(MEMBERS)) u_output_collector (
        .aclk, .aclken, .rst_n,
        .beat (beat_if.sink),
        .psum, .done, .out_valid, .out_sum, .out_col, .row_done
    );

endmodule

/* test/tb_conv_row_engine.sv */
// Testbench for the row convolution engine; rows and expected sums come from the case file
// Rows are driven back to back, every output sum, column and row_done flag is compared
`timescale 1ns/100ps

module tb_conv_row_engine;
    import conv_pkg::*;

    localparam int KW_MAX    = 7;
    localparam int MEMBERS   = 8;
    localparam int MEM_WORDS = 512;
    localparam int HDR_WORDS = 4 + MEMBERS;           // kw2 cols cins gaps, then the weights

    logic        aclk;
    logic        aclken;
    logic        rst_n;
    logic        in_valid;
    pixel_t      in_pixel;
    logic        in_config;
    kw2_t        in_kw2;
    col_t        in_cols;
    cin_t        in_cins;
    weight_t     in_weights [MEMBERS];
    logic        out_valid;
    psum_t       out_sum;
    col_t        out_col;
    logic        row_done;

    logic [31:0] case_mem [MEM_WORDS];                 // raw words of the case file
    psum_t       exp_sum [$];                          // expected results in output order
    col_t        exp_col [$];
    logic        exp_last [$];
    int          seed;
    int          cycles;
    int          cycle_limit;
    int          num_rows;
    logic        gap_mode;                             // random aclken gaps for the current row

    conv_row_engine #(.KW_MAX(KW_MAX), .MEMBERS(MEMBERS)) u_conv_row_engine (
        .aclk, .aclken, .rst_n, .in_valid, .in_pixel, .in_config,
        .in_kw2, .in_cols, .in_cins, .in_weights,
        .out_valid, .out_sum, .out_col, .row_done
    );

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;                           // 20 ns period

    task automatic fail_now();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_sum(input string name, input psum_t got, input psum_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_col(input string name, input col_t got, input col_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    // holds one input beat until a cycle with aclken high takes it
    task automatic send_beat(input logic cfg, input pixel_t px);
        logic en;
        en = 1'b0;
        while (!en) begin
            if (gap_mode) begin
                en = (($random(seed) & 3) != 0);       // roughly one cycle in four is a gap
            end else begin
                en = 1'b1;
            end
            in_valid  <= 1'b1;
            in_config <= cfg;
            in_pixel  <= px;
            aclken    <= en;
            @(posedge aclk);
        end
    endtask

    initial begin
        int ptr;
        int cols_v;
        int cins_v;
        int beats;
        seed      = 46496;
        cycles    = 0;
        gap_mode  = 1'b0;
        rst_n     = 1'b0;
        aclken    = 1'b1;
        in_valid  = 1'b0;
        in_pixel  = '0;
        in_config = 1'b0;
        in_kw2    = '0;
        in_cols   = '0;
        in_cins   = '0;
        for (int m = 0; m < MEMBERS; m++) begin
            in_weights[m] = '0;
        end
        $readmemh("test/conv_cases.txt", case_mem);
        num_rows = int'(case_mem[0]);
        ptr      = 1;
        beats    = 0;
        for (int r = 0; r < num_rows; r++) begin       // first pass only sizes the run
            cols_v = int'(case_mem[ptr + 1]);
            cins_v = int'(case_mem[ptr + 2]);
            beats  = beats + 1 + cols_v * cins_v;
            ptr    = ptr + HDR_WORDS + cols_v * cins_v + cols_v;
        end
        cycle_limit = beats * 4 + 200;
        repeat (8) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);
        ptr = 1;
        for (int r = 0; r < num_rows; r++) begin
            cols_v   = int'(case_mem[ptr + 1]);
            cins_v   = int'(case_mem[ptr + 2]);
            gap_mode = case_mem[ptr + 3][0];
            for (int o = 0; o < cols_v; o++) begin     // sums follow the pixels in the file
                exp_sum.push_back(psum_t'(case_mem[ptr + HDR_WORDS + cols_v * cins_v + o][23:0]));
                exp_col.push_back(col_t'(o));
                exp_last.push_back(o == cols_v - 1);
            end
            in_kw2  <= kw2_t'(case_mem[ptr][1:0]);
            in_cols <= col_t'(cols_v);
            in_cins <= cin_t'(cins_v);
            for (int m = 0; m < MEMBERS; m++) begin
                in_weights[m] <= weight_t'(case_mem[ptr + 4 + m][7:0]);
            end
            send_beat(1'b1, '0);
            for (int b = 0; b < cols_v * cins_v; b++) begin
                send_beat(1'b0, pixel_t'(case_mem[ptr + HDR_WORDS + b][7:0]));
            end
            ptr = ptr + HDR_WORDS + cols_v * cins_v + cols_v;
        end
        gap_mode  = 1'b0;
        in_valid  <= 1'b0;
        in_config <= 1'b0;
        aclken    <= 1'b1;                             // let the queue drain
        while (exp_sum.size() != 0) begin
            @(posedge aclk);
        end
        repeat (20) @(posedge aclk);                   // room for any stray output to show up
        $display("Everything OK");
        $finish;
    end

    // outputs change on the rising edge, so they are looked at on the falling one
    always @(negedge aclk) begin
        if (rst_n) begin
            if (row_done && !out_valid) begin
                $display("row_done is high without out_valid");
                fail_now();
            end else if (out_valid && exp_sum.size() == 0) begin
                $display("output appeared when no result was expected");
                fail_now();
            end else if (out_valid) begin
                check_sum("out_sum", out_sum, exp_sum.pop_front());
                check_col("out_col", out_col, exp_col.pop_front());
                check_flag("row_done", row_done, exp_last.pop_front());
            end
        end
    end

    always @(posedge aclk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
            if (cycles > cycle_limit) begin
                $display("timeout after %0d cycles with results still missing", cycles);
                fail_now();
            end
        end
    end

endmodule

/* all.f */
rtl/conv_pkg.sv
rtl/conv_beat_if.sv
rtl/beat_tagger.sv
rtl/pad_filter.sv
rtl/psum_chain.sv
rtl/output_collector.sv
rtl/conv_row_engine.sv
test/tb_conv_row_engine.sv

/* Makefile */
# Verilator build and run of the row convolution engine testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_conv_row_engine
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* test/conv_cases.txt */
// per case: kw2 cols cins gaps, 8 weights, pixels column by column with channels inner, sums
// hex two's complement throughout; the first word is the number of rows
06
// kw = 3 over six columns, one channel
01 06 01 00
01 03 ff 00 00 00 00 00
01 02 03 04 05 06
000001 000004 000007 00000a 00000d 000017
// kw = 5, three channels per column
02 06 03 00
01 fe 03 01 02 00 00 00
01 02 03 04 ff 02 00 03 03 fe 05 01 07 00 fd 02 02 02
000023 000011 00001a 000015 000010 00000e
// kw = 1, the other weights would show up if a hand-over took place
00 05 02 00
fd 05 05 05 05 05 05 05
02 05 fc 01 0a 0a 00 00 7f 80
ffffeb 000009 ffffc4 000000 000003
// kw = 7 followed directly by kw = 3
03 08 01 00
01 ff 02 01 03 fe 01 00
03 01 04 01 05 09 02 06
ffffff 000016 000005 00000a 000021 000010 000022 000006
01 07 02 00
02 ff 01 00 00 00 00 00
01 01 03 00 fe fe 05 05 00 01 04 f9 08 00
000001 fffffd 000014 ffffef 000010 00000d fffff2
// kw = 5 row again, now with random clock enable gaps
02 06 03 01
01 fe 03 01 02 00 00 00
01 02 03 04 ff 02 00 03 03 fe 05 01 07 00 fd 02 02 02
000023 000011 00001a 000015 000010 00000e
